// ==== hw/raypipe_pkg.sv ====
`default_nettype none

package raypipe_pkg;

	// ray store depth is 2**RAY_ID_W, node memory depth 2**NODE_ID_W
	localparam int RAY_ID_W = 8;
	localparam int NODE_ID_W = 10;
	localparam int COORD_W = 32;

	// split value fills what is left of one 32 bit scene-load word
	localparam int SPLIT_W = 32 - 2 - NODE_ID_W;

	typedef logic [COORD_W-1:0] coord_t;

	typedef enum logic [1:0] {
		axis_x = 2'b00,
		axis_y = 2'b01,
		axis_z = 2'b10,
		leaf   = 2'b11
	} node_type_e;

	typedef struct packed {
		node_type_e node_type;
		logic [NODE_ID_W-1:0] child;
		logic [SPLIT_W-1:0] split;
	} norm_node_t;

	typedef struct packed {
		coord_t x;
		coord_t y;
		coord_t z;
	} vec3_t;

	typedef struct packed {
		vec3_t origin;
		vec3_t dir;
	} ray_vec_t;

endpackage

`default_nettype wire

// ==== hw/node_req_if.sv ====
`default_nettype none

interface node_req_if;
	import raypipe_pkg::*;

	logic valid;
	logic stall;
	logic [RAY_ID_W-1:0] ray_id;
	logic [NODE_ID_W-1:0] node_id;
	coord_t t_min;
	coord_t t_max;

	// payload travels with valid, stall comes back
	modport src (output valid, ray_id, node_id, t_min, t_max, input stall);
	modport snk (input valid, ray_id, node_id, t_min, t_max, output stall);

endinterface

`default_nettype wire

// ==== hw/node_fetch_if.sv ====
`default_nettype none

interface node_fetch_if;
	import raypipe_pkg::*;

	logic valid;
	logic stall;
	logic [RAY_ID_W-1:0] ray_id;
	logic [NODE_ID_W-1:0] node_id;
	coord_t t_min;
	coord_t t_max;
	norm_node_t node;

	// request sideband plus the fetched tree node
	modport src (output valid, ray_id, node_id, t_min, t_max, node, input stall);
	modport snk (input valid, ray_id, node_id, t_min, t_max, node, output stall);

endinterface

`default_nettype wire

// ==== hw/trav_arbiter.sv ====
`default_nettype none

module trav_arbiter #(
	parameter int NUM_REQ = 4
) (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic [NUM_REQ-1:0] req_valid,
	input wire logic [NUM_REQ-1:0][raypipe_pkg::RAY_ID_W-1:0] req_ray_id,
	input wire logic [NUM_REQ-1:0][raypipe_pkg::NODE_ID_W-1:0] req_node_id,
	input wire logic [NUM_REQ-1:0][raypipe_pkg::COORD_W-1:0] req_t_min,
	input wire logic [NUM_REQ-1:0][raypipe_pkg::COORD_W-1:0] req_t_max,
	output logic [NUM_REQ-1:0] req_stall,
	node_req_if.src ds
);

	localparam int PTR_W = (NUM_REQ > 1) ? $clog2(NUM_REQ) : 1;

	logic [PTR_W-1:0] last_ptr;
	logic [PTR_W-1:0] pick;
	logic found;
	logic load;
	logic [NUM_REQ-1:0] grant;

	// output register free, or being emptied this cycle
	assign load = !ds.valid || !ds.stall;

	// search starts one past the last granted source
	always_comb begin
		int idx;
		pick = '0;
		found = 1'b0;
		for (int k = 1; k <= NUM_REQ; k++) begin
			idx = (int'(last_ptr) + k) % NUM_REQ;
			if (!found && req_valid[idx]) begin
				found = 1'b1;
				pick = PTR_W'(idx);
			end
		end
	end

	always_comb begin
		grant = '0;
		if (load && found)
			grant[pick] = 1'b1;
	end

	// every waiting source without a grant is held
	assign req_stall = req_valid & ~grant;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			last_ptr <= PTR_W'(NUM_REQ - 1);
			ds.valid <= 1'b0;
		end else if (load) begin
			ds.valid <= found;
			if (found)
				last_ptr <= pick;
		end
	end

	always_ff @(posedge clk) begin
		if (load && found) begin
			ds.ray_id <= req_ray_id[pick];
			ds.node_id <= req_node_id[pick];
			ds.t_min <= req_t_min[pick];
			ds.t_max <= req_t_max[pick];
		end
	end

endmodule

`default_nettype wire

// ==== hw/node_cache.sv ====
`default_nettype none

module node_cache #(
	parameter int NUM_LINES = 64,
	parameter int MEM_LAT = 3
) (
	input wire logic clk,
	input wire logic rst_n,
	node_req_if.snk us,
	node_fetch_if.src ds,
	input wire logic sl_we,
	input wire logic [raypipe_pkg::NODE_ID_W-1:0] sl_addr,
	input wire logic [31:0] sl_io,
	input wire logic segment_done
);
	import raypipe_pkg::*;

	localparam int IDX_W = $clog2(NUM_LINES);
	localparam int TAG_W = NODE_ID_W - IDX_W;
	localparam int CNT_W = $clog2(MEM_LAT + 1);

	typedef enum logic [1:0] {idle, lookup, miss_wait, out_full} cache_state_e;

	cache_state_e state;
	logic [CNT_W-1:0] wait_cnt;

	logic [NUM_LINES-1:0] line_valid;
	logic [TAG_W-1:0] line_tag [NUM_LINES];
	norm_node_t line_node [NUM_LINES];
	norm_node_t node_mem [2**NODE_ID_W];
	norm_node_t mem_rdata;

	// request parked while the line is fetched
	logic [RAY_ID_W-1:0] miss_ray_id;
	logic [NODE_ID_W-1:0] miss_node_id;
	coord_t miss_t_min;
	coord_t miss_t_max;

	logic [IDX_W-1:0] us_idx;
	logic [IDX_W-1:0] miss_idx;
	logic hit, busy, can_load;
	logic hit_acc, miss_acc, mem_done, deliver;

	assign us_idx = us.node_id[IDX_W-1:0];
	assign miss_idx = miss_node_id[IDX_W-1:0];
	assign hit = line_valid[us_idx] && (line_tag[us_idx] == us.node_id[NODE_ID_W-1:IDX_W]);

	// blocking cache, nothing accepted until a miss has been handed on
	assign busy = (state == miss_wait) || (state == out_full);
	assign can_load = !ds.valid || !ds.stall;
	assign us.stall = busy || (hit && !can_load);

	assign hit_acc = us.valid && !us.stall && hit;
	assign miss_acc = us.valid && !us.stall && !hit;
	assign mem_done = (state == miss_wait) && (wait_cnt == CNT_W'(MEM_LAT));
	assign deliver = ((state == out_full) || mem_done) && can_load;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= idle;
			wait_cnt <= '0;
		end else begin
			case (state)
				idle, lookup: begin
					wait_cnt <= '0;
					if (miss_acc)
						state <= miss_wait;
					else if (hit_acc || (ds.valid && ds.stall))
						state <= lookup;
					else
						state <= idle;
				end
				miss_wait: begin
					if (!mem_done)
						wait_cnt <= wait_cnt + 1'b1;
					else if (deliver)
						state <= lookup;
					else
						state <= out_full;
				end
				out_full: begin
					// line already filled, only the handoff is pending
					if (deliver)
						state <= lookup;
				end
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			line_valid <= '0;
		else if (segment_done)
			line_valid <= '0;
		else if (mem_done)
			line_valid[miss_idx] <= 1'b1;
	end

	always_ff @(posedge clk) begin
		if (mem_done) begin
			line_tag[miss_idx] <= miss_node_id[NODE_ID_W-1:IDX_W];
			line_node[miss_idx] <= mem_rdata;
		end
	end

	// backing node memory, filled by scene load
	always_ff @(posedge clk) begin
		if (sl_we)
			node_mem[sl_addr] <= norm_node_t'(sl_io);
		mem_rdata <= node_mem[miss_node_id];
	end

	always_ff @(posedge clk) begin
		if (miss_acc) begin
			miss_ray_id <= us.ray_id;
			miss_node_id <= us.node_id;
			miss_t_min <= us.t_min;
			miss_t_max <= us.t_max;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			ds.valid <= 1'b0;
		else if (hit_acc || deliver)
			ds.valid <= 1'b1;
		else if (!ds.stall)
			ds.valid <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (hit_acc) begin
			ds.ray_id <= us.ray_id;
			ds.node_id <= us.node_id;
			ds.t_min <= us.t_min;
			ds.t_max <= us.t_max;
			ds.node <= line_node[us_idx];
		end else if (deliver) begin
			ds.ray_id <= miss_ray_id;
			ds.node_id <= miss_node_id;
			ds.t_min <= miss_t_min;
			ds.t_max <= miss_t_max;
			ds.node <= mem_rdata;
		end
	end

endmodule

`default_nettype wire

// ==== hw/ray_join.sv ====
`default_nettype none

module ray_join (
	input wire logic clk,
	input wire logic rst_n,
	node_fetch_if.snk us,
	input wire logic rs_we,
	input wire logic [raypipe_pkg::RAY_ID_W-1:0] rs_waddr,
	input wire raypipe_pkg::ray_vec_t rs_wdata,
	output logic out_valid,
	output logic [raypipe_pkg::RAY_ID_W-1:0] out_ray_id,
	output logic [raypipe_pkg::NODE_ID_W-1:0] out_node_id,
	output raypipe_pkg::norm_node_t out_node,
	output logic [raypipe_pkg::COORD_W-1:0] out_t_min,
	output logic [raypipe_pkg::COORD_W-1:0] out_t_max,
	output logic [raypipe_pkg::COORD_W-1:0] out_origin,
	output logic [raypipe_pkg::COORD_W-1:0] out_dir,
	input wire logic out_stall
);
	import raypipe_pkg::*;

	ray_vec_t ray_store [2**RAY_ID_W];
	ray_vec_t ray_q;
	logic accept;

	assign us.stall = out_valid && out_stall;
	assign accept = us.valid && !us.stall;

	// same-cycle write and read of one ray returns the old vector
	always_ff @(posedge clk) begin
		if (rs_we)
			ray_store[rs_waddr] <= rs_wdata;
		if (accept)
			ray_q <= ray_store[us.ray_id];
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			out_valid <= 1'b0;
		else if (accept)
			out_valid <= 1'b1;
		else if (!out_stall)
			out_valid <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			out_ray_id <= us.ray_id;
			out_node_id <= us.node_id;
			out_node <= us.node;
			out_t_min <= us.t_min;
			out_t_max <= us.t_max;
		end
	end

	// keep only the split-axis components, leaves take z
	always_comb begin
		case (out_node.node_type)
			axis_x: begin
				out_origin = ray_q.origin.x;
				out_dir = ray_q.dir.x;
			end
			axis_y: begin
				out_origin = ray_q.origin.y;
				out_dir = ray_q.dir.y;
			end
			default: begin
				out_origin = ray_q.origin.z;
				out_dir = ray_q.dir.z;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== hw/raypipe_fetch_top.sv ====
`default_nettype none

module raypipe_fetch_top #(
	parameter int NUM_REQ = 4,
	parameter int NUM_LINES = 64,
	parameter int MEM_LAT = 3
) (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic [NUM_REQ-1:0] req_valid,
	input wire logic [NUM_REQ-1:0][raypipe_pkg::RAY_ID_W-1:0] req_ray_id,
	input wire logic [NUM_REQ-1:0][raypipe_pkg::NODE_ID_W-1:0] req_node_id,
	input wire logic [NUM_REQ-1:0][raypipe_pkg::COORD_W-1:0] req_t_min,
	input wire logic [NUM_REQ-1:0][raypipe_pkg::COORD_W-1:0] req_t_max,
	output logic [NUM_REQ-1:0] req_stall,
	input wire logic sl_we,
	input wire logic [raypipe_pkg::NODE_ID_W-1:0] sl_addr,
	input wire logic [31:0] sl_io,
	input wire logic segment_done,
	input wire logic rs_we,
	input wire logic [raypipe_pkg::RAY_ID_W-1:0] rs_waddr,
	input wire raypipe_pkg::ray_vec_t rs_wdata,
	output logic out_valid,
	output logic [raypipe_pkg::RAY_ID_W-1:0] out_ray_id,
	output logic [raypipe_pkg::NODE_ID_W-1:0] out_node_id,
	output raypipe_pkg::norm_node_t out_node,
	output logic [raypipe_pkg::COORD_W-1:0] out_t_min,
	output logic [raypipe_pkg::COORD_W-1:0] out_t_max,
	output logic [raypipe_pkg::COORD_W-1:0] out_origin,
	output logic [raypipe_pkg::COORD_W-1:0] out_dir,
	input wire logic out_stall
);

	node_req_if tarb_to_tcache ();
	node_fetch_if tcache_to_join ();

	trav_arbiter #(.NUM_REQ(NUM_REQ)) tarb (
		.clk,
		.rst_n,
		.req_valid,
		.req_ray_id,
		.req_node_id,
		.req_t_min,
		.req_t_max,
		.req_stall,
		.ds(tarb_to_tcache.src)
	);

	node_cache #(.NUM_LINES(NUM_LINES), .MEM_LAT(MEM_LAT)) tcache (
		.clk,
		.rst_n,
		.us(tarb_to_tcache.snk),
		.ds(tcache_to_join.src),
		.sl_we,
		.sl_addr,
		.sl_io,
		.segment_done
	);

	// ray store read joins the ray to its node
	ray_join rjoin (
		.clk,
		.rst_n,
		.us(tcache_to_join.snk),
		.rs_we,
		.rs_waddr,
		.rs_wdata,
		.out_valid,
		.out_ray_id,
		.out_node_id,
		.out_node,
		.out_t_min,
		.out_t_max,
		.out_origin,
		.out_dir,
		.out_stall
	);

endmodule

`default_nettype wire

// ==== tests/raypipe_fetch_sva.sv ====
`default_nettype none

module raypipe_fetch_sva #(
	parameter int GRANT_W = 1,
	parameter int DATA_W = 1
) (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic [GRANT_W-1:0] grant,
	input wire logic valid,
	input wire logic stall,
	input wire logic [DATA_W-1:0] data
);

	// never two sources granted in one cycle
	if (GRANT_W > 1) begin : g_one_grant
		a_one_grant: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(grant))
			else $error("more than one source granted");
	end

	// stalled item keeps valid and payload
	a_hold: assert property (@(posedge clk) disable iff (!rst_n)
		valid && stall |=> valid && $stable(data))
		else $error("payload changed while stalled");

	a_reset: assert property (@(posedge clk) !rst_n && $past(!rst_n) |-> !valid)
		else $error("valid high during reset");

endmodule

bind trav_arbiter raypipe_fetch_sva #(
	.GRANT_W(NUM_REQ),
	.DATA_W(raypipe_pkg::RAY_ID_W + raypipe_pkg::NODE_ID_W + 2 * raypipe_pkg::COORD_W)
) u_arb_sva (
	.clk(clk),
	.rst_n(rst_n),
	.grant(req_valid & ~req_stall),
	.valid(ds.valid),
	.stall(ds.stall),
	.data({ds.ray_id, ds.node_id, ds.t_min, ds.t_max})
);

bind ray_join raypipe_fetch_sva #(
	.GRANT_W(1),
	.DATA_W(raypipe_pkg::RAY_ID_W + raypipe_pkg::NODE_ID_W
		+ $bits(raypipe_pkg::norm_node_t) + 4 * raypipe_pkg::COORD_W)
) u_join_sva (
	.clk(clk),
	.rst_n(rst_n),
	.grant(1'b0),
	.valid(out_valid),
	.stall(out_stall),
	.data({out_ray_id, out_node_id, out_node, out_t_min, out_t_max, out_origin, out_dir})
);

`default_nettype wire

// ==== tests/tb_raypipe_fetch.sv ====
`default_nettype none

module tb_raypipe_fetch;
	import raypipe_pkg::*;

	localparam int NUM_REQ = 4;
	// each source owns one slice of the ray IDs
	localparam int RANGE = (2**RAY_ID_W) / NUM_REQ;
	localparam logic [31:0] SEED = 32'h88c2_4dad;
	// scene and ray loads take about 2600 cycles, then about 250 fetches under 40 cycles each
	localparam int MAX_CYCLES = 20000;

	typedef struct packed {
		logic [7:0] src;
		logic [RAY_ID_W-1:0] ray_id;
		logic [NODE_ID_W-1:0] node_id;
		coord_t t_min;
		coord_t t_max;
	} fetch_t;

	logic clk;
	logic rst_n;
	logic [NUM_REQ-1:0] req_valid;
	logic [NUM_REQ-1:0][RAY_ID_W-1:0] req_ray_id;
	logic [NUM_REQ-1:0][NODE_ID_W-1:0] req_node_id;
	logic [NUM_REQ-1:0][COORD_W-1:0] req_t_min;
	logic [NUM_REQ-1:0][COORD_W-1:0] req_t_max;
	logic [NUM_REQ-1:0] req_stall;
	logic sl_we;
	logic [NODE_ID_W-1:0] sl_addr;
	logic [31:0] sl_io;
	logic segment_done;
	logic rs_we;
	logic [RAY_ID_W-1:0] rs_waddr;
	ray_vec_t rs_wdata;
	logic out_valid;
	logic [RAY_ID_W-1:0] out_ray_id;
	logic [NODE_ID_W-1:0] out_node_id;
	norm_node_t out_node;
	coord_t out_t_min;
	coord_t out_t_max;
	coord_t out_origin;
	coord_t out_dir;
	logic out_stall = 1'b0;

	// reference copies of node memory and ray store
	norm_node_t ref_node [2**NODE_ID_W];
	ray_vec_t ref_ray [2**RAY_ID_W];
	fetch_t pend_q [$];
	logic [31:0] stim_st;
	logic [31:0] stall_st = SEED;
	logic stall_en;
	int cycle_cnt = 0;

	raypipe_fetch_top #(.NUM_REQ(NUM_REQ), .NUM_LINES(64), .MEM_LAT(3)) u_dut (.*);

	always #5 clk = ~clk;

	function automatic logic [31:0] lcg_next(input logic [31:0] st);
		return st * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic coord_t rand_word();
		stim_st = lcg_next(stim_st);
		return stim_st;
	endfunction

	function automatic ray_vec_t rand_ray();
		ray_vec_t v;
		v.origin.x = rand_word();
		v.origin.y = rand_word();
		v.origin.z = rand_word();
		v.dir.x = rand_word();
		v.dir.y = rand_word();
		v.dir.z = rand_word();
		return v;
	endfunction

	task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp) begin
			$display("FAIL time=%0t %s got=%0h exp=%0h", $time, name, got, exp);
			$display("Simulation failed");
			$fatal(1, "value mismatch on %s", name);
		end
	endtask

	// oldest pending request of the result's source must match
	task automatic check_result();
		int idx;
		fetch_t e;
		norm_node_t n;
		ray_vec_t r;
		coord_t exp_origin;
		coord_t exp_dir;
		idx = -1;
		for (int i = 0; i < pend_q.size(); i++) begin
			if (idx < 0 && int'(pend_q[i].src) == int'(out_ray_id) / RANGE)
				idx = i;
		end
		if (idx < 0) begin
			$display("result for ray %0d arrived with nothing pending from its source",
				out_ray_id);
			$display("Simulation failed");
			$fatal(1, "unexpected result");
		end else begin
			e = pend_q[idx];
			pend_q.delete(idx);
			n = ref_node[e.node_id];
			r = ref_ray[e.ray_id];
			case (n.node_type)
				axis_x: begin
					exp_origin = r.origin.x;
					exp_dir = r.dir.x;
				end
				axis_y: begin
					exp_origin = r.origin.y;
					exp_dir = r.dir.y;
				end
				axis_z, leaf: begin
					exp_origin = r.origin.z;
					exp_dir = r.dir.z;
				end
			endcase
			check("out_ray_id", 64'(out_ray_id), 64'(e.ray_id));
			check("out_node_id", 64'(out_node_id), 64'(e.node_id));
			check("out_node", 64'(out_node), 64'(n));
			check("out_t_min", 64'(out_t_min), 64'(e.t_min));
			check("out_t_max", 64'(out_t_max), 64'(e.t_max));
			check("out_origin", 64'(out_origin), 64'(exp_origin));
			check("out_dir", 64'(out_dir), 64'(exp_dir));
		end
	endtask

	task automatic accept_req(input int s);
		fetch_t e;
		e.src = 8'(s);
		e.ray_id = req_ray_id[s];
		e.node_id = req_node_id[s];
		e.t_min = req_t_min[s];
		e.t_max = req_t_max[s];
		pend_q.push_back(e);
	endtask

	task automatic wait_drain();
		do
			@(posedge clk);
		while (pend_q.size() != 0 || out_valid);
	endtask

	task automatic write_node(input logic [NODE_ID_W-1:0] addr, input logic [31:0] data);
		@(posedge clk);
		sl_we <= 1'b1;
		sl_addr <= addr;
		sl_io <= data;
		ref_node[addr] = norm_node_t'(data);
		@(posedge clk);
		sl_we <= 1'b0;
	endtask

	task automatic write_ray(input logic [RAY_ID_W-1:0] addr, input ray_vec_t data);
		@(posedge clk);
		rs_we <= 1'b1;
		rs_waddr <= addr;
		rs_wdata <= data;
		ref_ray[addr] = data;
		@(posedge clk);
		rs_we <= 1'b0;
	endtask

	task automatic end_segment();
		@(posedge clk);
		segment_done <= 1'b1;
		@(posedge clk);
		segment_done <= 1'b0;
	endtask

	task automatic fetch_one(input logic [RAY_ID_W-1:0] ray, input logic [NODE_ID_W-1:0] node);
		int s;
		s = int'(ray) / RANGE;
		@(posedge clk);
		req_valid[s] <= 1'b1;
		req_ray_id[s] <= ray;
		req_node_id[s] <= node;
		req_t_min[s] <= rand_word();
		req_t_max[s] <= rand_word();
		do
			@(posedge clk);
		while (req_stall[s]);
		accept_req(s);
		req_valid[s] <= 1'b0;
		wait_drain();
	endtask

	// all sources at once, random gaps, n_each requests per source
	task automatic run_random(input int n_each, input int node_span);
		int left [NUM_REQ];
		int total;
		total = NUM_REQ * n_each;
		foreach (left[s])
			left[s] = n_each;
		while (total > 0) begin
			@(posedge clk);
			for (int s = 0; s < NUM_REQ; s++) begin
				if (req_valid[s] && !req_stall[s]) begin
					accept_req(s);
					left[s]--;
					total--;
				end
				if (req_valid[s] && req_stall[s]) begin
					req_valid[s] <= 1'b1;
				end else if (left[s] > 0 && rand_word() % 4 != 0) begin
					req_valid[s] <= 1'b1;
					req_ray_id[s] <= RAY_ID_W'(s * RANGE + int'(rand_word() % RANGE));
					req_node_id[s] <= NODE_ID_W'(rand_word() % node_span);
					req_t_min[s] <= rand_word();
					req_t_max[s] <= rand_word();
				end else begin
					req_valid[s] <= 1'b0;
				end
			end
		end
		wait_drain();
	endtask

	task automatic test_single_fetch();
		end_segment();
		// first one misses, the repeat hits the filled line
		fetch_one(8'd5, 10'd300);
		fetch_one(8'd5, 10'd300);
		fetch_one(8'd70, 10'd300);
	endtask

	task automatic test_axis_select();
		logic [31:0] w;
		write_ray(8'd9, rand_ray());
		for (int t = 0; t < 4; t++) begin
			w = rand_word();
			write_node(NODE_ID_W'(900 + t), {2'(t), w[29:0]});
		end
		end_segment();
		for (int t = 0; t < 4; t++)
			fetch_one(8'd9, NODE_ID_W'(900 + t));
	endtask

	task automatic test_backpressure();
		@(posedge clk);
		stall_en <= 1'b1;
		run_random(20, 256);
		@(posedge clk);
		stall_en <= 1'b0;
	endtask

	task automatic test_segment_reload();
		fetch_one(8'd12, 10'd77);
		write_node(10'd77, rand_word());
		end_segment();
		fetch_one(8'd12, 10'd77);
		write_ray(8'd12, rand_ray());
		fetch_one(8'd12, 10'd77);
	endtask

	always @(posedge clk) begin
		stall_st <= lcg_next(stall_st);
		out_stall <= stall_en && stall_st[31];
	end

	always @(posedge clk) begin
		if (rst_n && out_valid && !out_stall)
			check_result();
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= MAX_CYCLES) begin
			$display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
			$display("Simulation failed");
			$fatal(1, "timeout");
		end
	end

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		req_valid = '0;
		req_ray_id = '0;
		req_node_id = '0;
		req_t_min = '0;
		req_t_max = '0;
		sl_we = 1'b0;
		sl_addr = '0;
		sl_io = '0;
		segment_done = 1'b0;
		rs_we = 1'b0;
		rs_waddr = '0;
		rs_wdata = '0;
		stim_st = SEED;
		stall_en = 1'b0;
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);
		check("req_stall", 64'(req_stall), 64'd0);
		check("out_valid", 64'(out_valid), 64'd0);
		for (int i = 0; i < 2**NODE_ID_W; i++)
			write_node(NODE_ID_W'(i), rand_word());
		for (int i = 0; i < 2**RAY_ID_W; i++)
			write_ray(RAY_ID_W'(i), rand_ray());
		test_single_fetch();
		test_axis_select();
		// narrow node range so lines get reused
		run_random(40, 128);
		test_backpressure();
		test_segment_reload();
		$display("Simulation passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== compile.f ====
hw/raypipe_pkg.sv
hw/node_req_if.sv
hw/node_fetch_if.sv
hw/trav_arbiter.sv
hw/node_cache.sv
hw/ray_join.sv
hw/raypipe_fetch_top.sv
tests/raypipe_fetch_sva.sv
tests/tb_raypipe_fetch.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_raypipe_fetch
FILELIST ?= compile.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0
PASS_MSG ?= Simulation passed

BIN := $(OBJ_DIR)/V$(TOP)
SRCS := $(wildcard hw/*.sv tests/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$($(BIN) 2>&1)"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
